/* Makefile */
SIM := obj_dir/Vhud_tb
SOURCES := $(wildcard hdl/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module hud_tb -f compile.f -o Vhud_tb

run: $(SIM) tb/hud_trace.txt
	./$(SIM) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
hdl/hud_pkg.sv
hdl/vga_timing.sv
hdl/game_timer.sv
hdl/glyph_rom.sv
hdl/rom_arbiter.sv
hdl/digit_sprite.sv
hdl/hud_overlay.sv
tb/hud_assertions.sv
tb/hud_tb.sv

/* hdl/digit_sprite.sv */
`timescale 1ns/10ps
`default_nettype none

module digit_sprite #(
  parameter hud_pkg::coord_t ORIGIN_X = '0,
  parameter hud_pkg::coord_t ORIGIN_Y = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  hud_pkg::count_t  value,
  input  hud_pkg::coord_t  h_count,
  input  hud_pkg::coord_t  v_count,
  input  logic             line_start,
  output hud_pkg::wb_req_t wb_req,
  input  hud_pkg::wb_rsp_t wb_rsp,
  output hud_pkg::color_t  pixel
);

  hud_pkg::coord_t     next_v;
  hud_pkg::coord_t     next_row;
  logic                next_in_rows;
  logic [3:0]          tens;
  logic [3:0]          ones;
  logic [3:0]          tens_q;
  logic [3:0]          ones_q;
  logic [3:0]          row_q;
  logic [3:0]          fetch_digit;
  hud_pkg::rom_addr_t  fetch_adr;
  logic                busy;
  logic [1:0]          fetch_cnt;
  logic                row_valid;
  hud_pkg::glyph_row_t tens_row;
  hud_pkg::glyph_row_t ones_row;
  hud_pkg::coord_t     rel_x;
  hud_pkg::coord_t     col;
  logic [3:0]          bit_idx;
  logic                in_cols;
  logic                in_tens;
  logic                pix_set;

  // line_start comes while v_count still holds the line being left
  assign next_v = (v_count == hud_pkg::V_TOTAL - 1'b1) ? '0 : v_count + 1'b1;
  assign next_row = next_v - ORIGIN_Y;
  assign next_in_rows = (next_v >= ORIGIN_Y) && (next_row < hud_pkg::GLYPH_H);

  assign tens = 4'(value / 7'd10);
  assign ones = 4'(value % 7'd10);

  // first read is the tens row, second the ones row
  assign fetch_digit = fetch_cnt[0] ? ones_q : tens_q;
  assign fetch_adr = hud_pkg::rom_addr_t'(fetch_digit) * hud_pkg::rom_addr_t'(hud_pkg::GLYPH_H)
                   + hud_pkg::rom_addr_t'(row_q);

  assign wb_req = '{cyc: busy, stb: busy, adr: fetch_adr};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      fetch_cnt <= '0;
      row_valid <= 1'b0;
    end else if (line_start) begin
      busy      <= next_in_rows;  // lines outside the sprite stay invalid
      fetch_cnt <= '0;
      row_valid <= 1'b0;
    end else if (busy && wb_rsp.ack) begin
      fetch_cnt <= fetch_cnt + 2'd1;
      if (fetch_cnt == 2'd1) begin
        busy      <= 1'b0;
        row_valid <= 1'b1;
      end
    end
  end

  // value is sampled once per line so both digits belong to the same count
  always_ff @(posedge clk) begin
    if (line_start) begin
      tens_q <= tens;
      ones_q <= ones;
      row_q  <= next_row[3:0];
    end
    if (busy && wb_rsp.ack) begin
      if (fetch_cnt[0]) begin
        ones_row <= wb_rsp.dat;
      end else begin
        tens_row <= wb_rsp.dat;
      end
    end
  end

  assign rel_x   = h_count - ORIGIN_X;
  assign in_cols = (h_count >= ORIGIN_X) && (rel_x < hud_pkg::SPRITE_W);
  assign in_tens = (rel_x < hud_pkg::GLYPH_W);
  assign col     = in_tens ? rel_x : rel_x - hud_pkg::GLYPH_W;
  assign bit_idx = 4'(hud_pkg::GLYPH_W - 1'b1 - col);

  always_comb begin
    pix_set = 1'b0;
    if (row_valid && in_cols) begin
      if (in_tens) begin
        pix_set = (tens_q != 4'd0) && tens_row[bit_idx];  // no leading zero
      end else begin
        pix_set = ones_row[bit_idx];
      end
    end
  end

  always_ff @(posedge clk) begin
    pixel <= pix_set ? hud_pkg::COUNTER_COLOR : hud_pkg::TRANSPARENT_COLOR;
  end

endmodule

`default_nettype wire

/* hdl/game_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module game_timer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  hud_pkg::count_t duration,
  input  logic            sec_tick,
  output hud_pkg::count_t time_left
);

  hud_pkg::count_t load_value;

  // only two digits can be drawn, so longer durations saturate
  assign load_value = (duration > hud_pkg::DIGIT_MAX) ? hud_pkg::DIGIT_MAX : duration;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      time_left <= '0;
    end else if (start) begin
      time_left <= load_value;  // a new game overrides a tick in the same cycle
    end else if (sec_tick && (time_left != '0)) begin
      time_left <= time_left - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/glyph_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module glyph_rom (
  input  logic             clk,
  input  logic             rst_n,
  input  hud_pkg::wb_req_t wb_req,
  output hud_pkg::wb_rsp_t wb_rsp
);

  logic                strobe;
  logic                ack;
  hud_pkg::glyph_row_t dat;

  // a held strobe is answered once, the cycle after ack starts a new access
  assign strobe = wb_req.cyc && wb_req.stb && !ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (strobe) begin
      if (wb_req.adr < hud_pkg::GLYPH_ROWS) begin
        dat <= hud_pkg::GLYPH_ROM[wb_req.adr];
      end else begin
        dat <= '0;  // digits above 9 come out blank
      end
    end
  end

  assign wb_rsp = '{ack: ack, dat: dat};

endmodule

`default_nettype wire

/* hdl/hud_overlay.sv */
`timescale 1ns/10ps
`default_nettype none

module hud_overlay (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  hud_pkg::count_t duration,
  input  logic            sec_tick,
  input  hud_pkg::count_t score,
  output hud_pkg::color_t rgb,
  output logic            de,
  output logic            hsync,
  output logic            vsync
);

  hud_pkg::coord_t  h_count;
  hud_pkg::coord_t  v_count;
  logic             vid_de;
  logic             vid_hsync;
  logic             vid_vsync;
  logic             line_start;
  hud_pkg::count_t  time_left;
  hud_pkg::color_t  timer_px;
  hud_pkg::color_t  score_px;
  hud_pkg::color_t  mix;
  hud_pkg::wb_req_t timer_req;
  hud_pkg::wb_req_t score_req;
  hud_pkg::wb_req_t rom_req;
  hud_pkg::wb_rsp_t timer_rsp;
  hud_pkg::wb_rsp_t score_rsp;
  hud_pkg::wb_rsp_t rom_rsp;
  logic             de_d;
  logic             hsync_d;
  logic             vsync_d;

  vga_timing u_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .h_count    (h_count),
    .v_count    (v_count),
    .de         (vid_de),
    .hsync      (vid_hsync),
    .vsync      (vid_vsync),
    .line_start (line_start)
  );

  game_timer u_game_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .duration  (duration),
    .sec_tick  (sec_tick),
    .time_left (time_left)
  );

  digit_sprite #(
    .ORIGIN_X (hud_pkg::TIMER_X),
    .ORIGIN_Y (hud_pkg::TIMER_Y)
  ) u_timer_digits (
    .clk        (clk),
    .rst_n      (rst_n),
    .value      (time_left),
    .h_count    (h_count),
    .v_count    (v_count),
    .line_start (line_start),
    .wb_req     (timer_req),
    .wb_rsp     (timer_rsp),
    .pixel      (timer_px)
  );

  digit_sprite #(
    .ORIGIN_X (hud_pkg::SCORE_X),
    .ORIGIN_Y (hud_pkg::SCORE_Y)
  ) u_score_digits (
    .clk        (clk),
    .rst_n      (rst_n),
    .value      (score),
    .h_count    (h_count),
    .v_count    (v_count),
    .line_start (line_start),
    .wb_req     (score_req),
    .wb_rsp     (score_rsp),
    .pixel      (score_px)
  );

  // timer renderer on port 0 has priority
  rom_arbiter u_arbiter (
    .clk    (clk),
    .rst_n  (rst_n),
    .m0_req (timer_req),
    .m1_req (score_req),
    .m0_rsp (timer_rsp),
    .m1_rsp (score_rsp),
    .s_req  (rom_req),
    .s_rsp  (rom_rsp)
  );

  glyph_rom u_glyph_rom (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (rom_req),
    .wb_rsp (rom_rsp)
  );

  always_comb begin
    if (timer_px != hud_pkg::TRANSPARENT_COLOR) begin
      mix = timer_px;
    end else if (score_px != hud_pkg::TRANSPARENT_COLOR) begin
      mix = score_px;
    end else begin
      mix = hud_pkg::BG_COLOR;
    end
  end

  // the first stage lines the syncs up with the registered sprite pixels
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_d    <= 1'b0;
      hsync_d <= 1'b1;
      vsync_d <= 1'b1;
      rgb     <= '0;
      de      <= 1'b0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      de_d    <= vid_de;
      hsync_d <= vid_hsync;
      vsync_d <= vid_vsync;
      rgb     <= de_d ? mix : '0;  // black in blanking
      de      <= de_d;
      hsync   <= hsync_d;
      vsync   <= vsync_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/hud_pkg.sv */
`default_nettype none

package hud_pkg;

  typedef logic [9:0] coord_t;      // screen or sprite-relative pixel position
  typedef logic [7:0] color_t;      // RGB332
  typedef logic [6:0] count_t;      // two decimal digits
  typedef logic [9:0] glyph_row_t;  // leftmost pixel in bit 9
  typedef logic [7:0] rom_addr_t;

  localparam coord_t H_ACTIVE = 10'd640;
  localparam coord_t H_FRONT  = 10'd16;
  localparam coord_t H_SYNC   = 10'd96;
  localparam coord_t H_BACK   = 10'd48;
  localparam coord_t V_ACTIVE = 10'd480;
  localparam coord_t V_FRONT  = 10'd10;
  localparam coord_t V_SYNC   = 10'd2;
  localparam coord_t V_BACK   = 10'd33;

  localparam coord_t H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam coord_t H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam coord_t H_TOTAL      = H_SYNC_END + H_BACK;   // 800 pixels per line
  localparam coord_t V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam coord_t V_SYNC_END   = V_SYNC_START + V_SYNC;
  localparam coord_t V_TOTAL      = V_SYNC_END + V_BACK;   // 525 lines per frame

  localparam coord_t GLYPH_W  = 10'd10;
  localparam coord_t GLYPH_H  = 10'd13;
  localparam coord_t SPRITE_W = GLYPH_W + GLYPH_W;  // tens cell then ones cell

  localparam coord_t TIMER_X = 10'd8;
  localparam coord_t TIMER_Y = 10'd8;
  localparam coord_t SCORE_X = 10'd600;
  localparam coord_t SCORE_Y = 10'd8;

  localparam count_t DIGIT_MAX = 7'd99;

  localparam color_t COUNTER_COLOR     = 8'h00;
  localparam color_t TRANSPARENT_COLOR = 8'hE3;
  localparam color_t BG_COLOR          = 8'h25;

  // the four row shapes that the seven-segment style glyphs are built from
  localparam glyph_row_t G_BAR = 10'b0111111110;
  localparam glyph_row_t G_LFT = 10'b0110000000;
  localparam glyph_row_t G_RGT = 10'b0000000110;
  localparam glyph_row_t G_BTH = 10'b0110000110;

  localparam rom_addr_t GLYPH_ROWS = 8'd130;

  // digit d, row r sits at d * 13 + r
  localparam glyph_row_t GLYPH_ROM [GLYPH_ROWS] = '{
    G_BAR, G_BAR, G_BTH, G_BTH, G_BTH, G_BTH, G_BTH,  // 0
    G_BTH, G_BTH, G_BTH, G_BTH, G_BAR, G_BAR,
    G_RGT, G_RGT, G_RGT, G_RGT, G_RGT, G_RGT, G_RGT,  // 1
    G_RGT, G_RGT, G_RGT, G_RGT, G_RGT, G_RGT,
    G_BAR, G_BAR, G_RGT, G_RGT, G_RGT, G_RGT, G_BAR,  // 2
    G_LFT, G_LFT, G_LFT, G_LFT, G_BAR, G_BAR,
    G_BAR, G_BAR, G_RGT, G_RGT, G_RGT, G_RGT, G_BAR,  // 3
    G_RGT, G_RGT, G_RGT, G_RGT, G_BAR, G_BAR,
    G_BTH, G_BTH, G_BTH, G_BTH, G_BTH, G_BTH, G_BAR,  // 4
    G_RGT, G_RGT, G_RGT, G_RGT, G_RGT, G_RGT,
    G_BAR, G_BAR, G_LFT, G_LFT, G_LFT, G_LFT, G_BAR,  // 5
    G_RGT, G_RGT, G_RGT, G_RGT, G_BAR, G_BAR,
    G_BAR, G_BAR, G_LFT, G_LFT, G_LFT, G_LFT, G_BAR,  // 6
    G_BTH, G_BTH, G_BTH, G_BTH, G_BAR, G_BAR,
    G_BAR, G_BAR, G_RGT, G_RGT, G_RGT, G_RGT, G_RGT,  // 7
    G_RGT, G_RGT, G_RGT, G_RGT, G_RGT, G_RGT,
    G_BAR, G_BAR, G_BTH, G_BTH, G_BTH, G_BTH, G_BAR,  // 8
    G_BTH, G_BTH, G_BTH, G_BTH, G_BAR, G_BAR,
    G_BAR, G_BAR, G_BTH, G_BTH, G_BTH, G_BTH, G_BAR,  // 9
    G_RGT, G_RGT, G_RGT, G_RGT, G_BAR, G_BAR
  };

  typedef struct packed {
    logic      cyc;
    logic      stb;
    rom_addr_t adr;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    glyph_row_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* hdl/rom_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_arbiter (
  input  logic             clk,
  input  logic             rst_n,
  input  hud_pkg::wb_req_t m0_req,
  input  hud_pkg::wb_req_t m1_req,
  output hud_pkg::wb_rsp_t m0_rsp,
  output hud_pkg::wb_rsp_t m1_rsp,
  output hud_pkg::wb_req_t s_req,
  input  hud_pkg::wb_rsp_t s_rsp
);

  logic             granted;  // a master owned the bus last cycle
  logic             owner;    // 0 for the timer renderer, 1 for the score renderer
  logic             hold;
  logic             sel;
  hud_pkg::wb_req_t owner_req;

  assign owner_req = owner ? m1_req : m0_req;

  // the grant lasts as long as its owner keeps cyc up
  assign hold = granted && owner_req.cyc;

  // on a free bus master 0 wins, and the choice goes through in the same cycle
  assign sel = hold ? owner : !m0_req.cyc;

  assign s_req = sel ? m1_req : m0_req;

  assign m0_rsp = '{ack: s_rsp.ack && !sel, dat: s_rsp.dat};
  assign m1_rsp = '{ack: s_rsp.ack && sel, dat: s_rsp.dat};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      granted <= 1'b0;
      owner   <= 1'b0;
    end else begin
      granted <= s_req.cyc;
      owner   <= sel;
    end
  end

endmodule

`default_nettype wire

/* hdl/vga_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_timing (
  input  logic            clk,
  input  logic            rst_n,
  output hud_pkg::coord_t h_count,
  output hud_pkg::coord_t v_count,
  output logic            de,
  output logic            hsync,
  output logic            vsync,
  output logic            line_start
);

  logic h_last;
  logic v_last;

  assign h_last = (h_count == hud_pkg::H_TOTAL - 1'b1);
  assign v_last = (v_count == hud_pkg::V_TOTAL - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_last) begin
      h_count <= '0;
      v_count <= v_last ? '0 : v_count + 1'b1;
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign de = (h_count < hud_pkg::H_ACTIVE) && (v_count < hud_pkg::V_ACTIVE);

  // both syncs are negative pulses
  assign hsync = !((h_count >= hud_pkg::H_SYNC_START) && (h_count < hud_pkg::H_SYNC_END));
  assign vsync = !((v_count >= hud_pkg::V_SYNC_START) && (v_count < hud_pkg::V_SYNC_END));

  // the renderers prefetch the following line from the first blanking pixel
  assign line_start = (h_count == hud_pkg::H_ACTIVE);

endmodule

`default_nettype wire

/* tb/hud_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module hud_assertions (
  input logic             clk,
  input logic             rst_n,
  input hud_pkg::wb_req_t m0_req,
  input hud_pkg::wb_req_t m1_req,
  input hud_pkg::wb_rsp_t m0_rsp,
  input hud_pkg::wb_rsp_t m1_rsp,
  input hud_pkg::wb_req_t s_req,
  input hud_pkg::wb_rsp_t s_rsp,
  input logic             hold,
  input logic             owner
);

  logic [3:0] m0_wait;  // cycles a strobe has waited for its ack
  logic [3:0] m1_wait;
  int         fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m0_wait <= '0;
      m1_wait <= '0;
    end else begin
      if (m0_req.stb && !m0_rsp.ack) begin
        m0_wait <= (m0_wait == 4'hF) ? m0_wait : m0_wait + 4'd1;
      end else begin
        m0_wait <= '0;
      end
      if (m1_req.stb && !m1_rsp.ack) begin
        m1_wait <= (m1_wait == 4'hF) ? m1_wait : m1_wait + 4'd1;
      end else begin
        m1_wait <= '0;
      end
    end
  end

  ack_with_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    s_rsp.ack |-> (s_req.cyc && s_req.stb))
    else begin
      $error("glyph ROM acknowledged without an active strobe");
      fail_count++;
    end

  // an ack may only reach the master that holds the grant and strobes
  m0_ack_owned: assert property (@(posedge clk) disable iff (!rst_n)
    m0_rsp.ack |-> (hold && !owner && m0_req.stb))
    else begin
      $error("timer renderer acknowledged without owning the bus");
      fail_count++;
    end

  m1_ack_owned: assert property (@(posedge clk) disable iff (!rst_n)
    m1_rsp.ack |-> (hold && owner && m1_req.stb))
    else begin
      $error("score renderer acknowledged without owning the bus");
      fail_count++;
    end

  m0_ack_in_time: assert property (@(posedge clk) disable iff (!rst_n)
    m0_wait <= 4'd8)
    else begin
      $error("timer renderer strobe waited more than 8 cycles");
      fail_count++;
    end

  m1_ack_in_time: assert property (@(posedge clk) disable iff (!rst_n)
    m1_wait <= 4'd8)
    else begin
      $error("score renderer strobe waited more than 8 cycles");
      fail_count++;
    end

endmodule

bind rom_arbiter hud_assertions u_assertions (
  .clk    (clk),
  .rst_n  (rst_n),
  .m0_req (m0_req),
  .m1_req (m1_req),
  .m0_rsp (m0_rsp),
  .m1_rsp (m1_rsp),
  .s_req  (s_req),
  .s_rsp  (s_rsp),
  .hold   (hold),
  .owner  (owner)
);

`default_nettype wire

/* tb/hud_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module hud_tb;

  logic            clk;
  logic            rst_n;
  logic            start;
  hud_pkg::count_t duration;
  logic            sec_tick;
  hud_pkg::count_t score;
  hud_pkg::color_t rgb;
  logic            de;
  logic            hsync;
  logic            vsync;

  int              frame_count = 0;
  int              col = 0;
  int              row = 0;
  logic            synced = 1'b0;
  logic            in_vsync = 1'b0;
  logic            pix_valid = 1'b0;
  int              pix_x = 0;
  int              pix_y = 0;
  hud_pkg::color_t pix_rgb = '0;

  int              hs_low = 0;
  int              de_gap = 0;
  logic            after_de = 1'b0;

  int              limit = 0;
  int              tests = 0;
  int              checks = 0;
  int              errors = 0;
  int              test_checks = 0;
  int              test_errors = 0;
  logic            test_open = 1'b0;
  logic [127:0]    test_name = '0;

  hud_overlay UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .duration (duration),
    .sec_tick (sec_tick),
    .score    (score),
    .rgb      (rgb),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // rows of the output pixel position restart at every vsync pulse
  always @(negedge clk) begin
    pix_valid <= 1'b0;
    if (!vsync) begin
      if (!in_vsync) begin
        frame_count <= frame_count + 1;
      end
      in_vsync <= 1'b1;
      synced   <= 1'b1;
      col      <= 0;
      row      <= 0;
    end else begin
      in_vsync <= 1'b0;
      if (de) begin
        pix_valid <= synced;
        pix_x     <= col;
        pix_y     <= row;
        pix_rgb   <= rgb;
        col       <= col + 1;
      end else if (col != 0) begin
        col <= 0;
        row <= row + 1;
      end
    end
  end

  // hsync falls after the 16 pixel front porch and stays low for 96 pixels
  always @(negedge clk) begin
    if (de) begin
      de_gap   <= 0;
      after_de <= 1'b1;
    end else begin
      de_gap <= de_gap + 1;
      if (rgb !== '0) begin
        $display("** Error: rgb = 0x%h, expected 0x00 outside de", rgb);
        errors++;
        test_errors++;
      end
    end
    if (!hsync) begin
      hs_low <= hs_low + 1;
      if (hs_low == 0 && after_de) begin
        after_de <= 1'b0;
        if (de_gap != 16) begin
          $display("** Error: hsync fell 0x%h pixels after de, expected 0x10", de_gap);
          errors++;
          test_errors++;
        end
      end
    end else begin
      if (hs_low != 0 && hs_low != 96) begin
        $display("** Error: hsync low for 0x%h pixels, expected 0x60", hs_low);
        errors++;
        test_errors++;
      end
      hs_low <= 0;
    end
  end

  task automatic load_duration(input int value);
    @(posedge clk);
    duration <= hud_pkg::count_t'(value);
    start    <= 1'b1;
    @(posedge clk);
    start    <= 1'b0;
  endtask

  task automatic pulse_ticks(input int count);
    repeat (count) begin
      @(posedge clk);
      sec_tick <= 1'b1;
      @(posedge clk);
      sec_tick <= 1'b0;
    end
  endtask

  task automatic set_score(input int value);
    @(posedge clk);
    score <= hud_pkg::count_t'(value);
  endtask

  task automatic wait_frame();
    int first;
    first = frame_count;
    while (frame_count == first) begin
      @(posedge clk);
    end
  endtask

  task automatic check_pixel(input int x, input int y, input int expected);
    @(posedge clk);
    while (!(pix_valid && pix_x == x && pix_y == y)) begin
      @(posedge clk);
    end
    checks++;
    test_checks++;
    if (pix_rgb !== expected[7:0]) begin
      $display("** Error: rgb = 0x%h, expected 0x%h at column %0d row %0d",
               pix_rgb, expected[7:0], x, y);
      errors++;
      test_errors++;
    end
  endtask

  task automatic close_test();
    if (test_open) begin
      $display("test %0s: %0d checks, %0d errors, %0s", test_name, test_checks,
               test_errors, (test_errors == 0) ? "passed" : "failed");
    end
    test_open = 1'b0;
  endtask

  initial begin : run_trace
    int           fd;
    int           code;
    int           frames;
    int           a;
    int           b;
    int           c;
    logic [63:0]  token;
    logic [127:0] name;
    logic [1023:0] rest;

    rst_n    = 1'b0;
    start    = 1'b0;
    duration = '0;
    sec_tick = 1'b0;
    score    = '0;
    frames   = 0;

    // each frame wait may take up to four frames before it is given up
    fd = $fopen("tb/hud_trace.txt", "r");
    if (fd != 0) begin
      code = $fscanf(fd, "%s", token);
      while (code == 1) begin
        if (token == 64'("frame")) begin
          frames++;
        end
        code = $fscanf(fd, "%s", token);
      end
      $fclose(fd);
    end
    limit = 4 * int'(hud_pkg::H_TOTAL) * int'(hud_pkg::V_TOTAL) * frames + 1000;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    if (fd == 0) begin
      $display("could not open the trace file tb/hud_trace.txt");
      errors++;
    end else begin
      fd = $fopen("tb/hud_trace.txt", "r");
      code = $fscanf(fd, "%s", token);
      while (code == 1) begin
        if (token == 64'("#")) begin
          code = $fgets(rest, fd);
        end else if (token == 64'("test")) begin
          code = $fscanf(fd, "%s", name);
          close_test();
          tests++;
          test_name   = name;
          test_open   = 1'b1;
          test_checks = 0;
          test_errors = 0;
        end else if (token == 64'("load")) begin
          code = $fscanf(fd, "%d", a);
          load_duration(a);
        end else if (token == 64'("tick")) begin
          code = $fscanf(fd, "%d", a);
          pulse_ticks(a);
        end else if (token == 64'("score")) begin
          code = $fscanf(fd, "%d", a);
          set_score(a);
        end else if (token == 64'("frame")) begin
          wait_frame();
        end else if (token == 64'("check")) begin
          code = $fscanf(fd, "%d %d %h", a, b, c);
          check_pixel(a, b, c);
        end else begin
          $display("unknown command %0s in the trace file", token);
          errors++;
        end
        code = $fscanf(fd, "%s", token);
      end
      $fclose(fd);
    end

    close_test();
    if (UUT.u_arbiter.u_assertions.fail_count != 0) begin
      $display("%0d assertion failures in the ROM arbiter",
               UUT.u_arbiter.u_assertions.fail_count);
      errors += UUT.u_arbiter.u_assertions.fail_count;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the trace did not complete within %0d clock cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/hud_trace.txt */
# commands: test name, load n, tick n, score n, frame, check x y rgb
# x and y are screen column and row, rgb is the expected colour in hex
test reset_zero
frame
check 9 8 25
check 18 8 25
check 19 8 00
check 601 8 25
check 611 8 00
check 22 12 25
check 26 12 00
check 320 240 25
test timer_57
load 57
frame
check 8 8 25
check 9 8 00
check 19 8 00
check 15 11 25
check 19 11 25
check 25 11 00
check 12 14 00
check 9 16 25
check 15 16 00
test countdown
load 57
tick 3
frame
check 22 8 25
check 19 11 00
check 12 14 00
tick 60
frame
check 9 8 25
check 19 8 00
check 22 12 25
test clamp_99
load 120
frame
check 9 8 00
check 16 11 00
check 19 11 00
check 9 16 25
check 25 16 00
check 22 20 00
test score_83
score 83
frame
check 9 11 00
check 601 11 00
check 611 11 25
check 617 11 00
check 614 14 00
check 19 16 25
check 601 16 00
check 611 16 25
test edges
frame
check 28 8 25
check 620 8 25
check 9 21 25
check 19 21 25
check 601 21 25
